// File: Makefile
# Verilator build and run for the APB subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_apb_subsystem
FILELIST  ?= apb_subsystem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^ALL CHECKS PASSED$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: apb_subsystem.f
+incdir+common
common/apb_bus_pkg.sv
common/pwr_pkg.sv
common/pwr_ctrl_if.sv
bridge/ahb_apb_bridge.sv
bridge/apb_slot_decode.sv
power/pwr_ctrl_regs.sv
power/pwr_wake_gate.sv
source/apb_subsystem.sv
tests/tb_apb_subsystem.sv

// File: bridge/ahb_apb_bridge.sv
// AHB-lite to APB bridge
// Latches one AHB transfer, lets the decoder check the address, then
// runs an APB SETUP and ACCESS phase or a two-cycle ERROR response.
// One transfer in flight, wait states come only from pready

`include "apb_sub_cfg.svh"

module ahb_apb_bridge (
  input  logic                   i_hclk,
  input  logic                   i_rst,
  // AHB-lite slave port
  input  logic                   i_hsel,
  input  logic [31:0]            i_haddr,
  input  logic [1:0]             i_htrans,
  input  logic                   i_hwrite,
  input  logic [`DATA_W-1:0]     i_hwdata,
  input  logic                   i_hready_in,
  output logic [`DATA_W-1:0]     o_hrdata,
  output logic                   o_hready,
  output apb_bus_pkg::hresp_e    o_hresp,
  // From slot decoder
  input  logic                   i_dec_valid,
  input  logic [`DATA_W-1:0]     i_prdata,
  input  logic                   i_pready,
  // APB master side
  output apb_bus_pkg::apb_addr_u o_paddr,
  output logic                   o_pwrite,
  output logic [`DATA_W-1:0]     o_pwdata,
  output logic                   o_pactive,
  output logic                   o_penable
);

  import apb_bus_pkg::*;

  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  typedef enum logic [2:0] {
    IDLE,
    SETUP,
    ACCESS,
    ERR1,
    ERR2
  } state_e;

  state_e             state;
  logic               pend;        // Address latched, decoder result due
  logic               accept;
  apb_addr_u          paddr_q;
  logic               pwrite_q;
  logic [`DATA_W-1:0] pwdata_q;
  logic [`DATA_W-1:0] hrdata_q;

  // ----------------------------------------------------------
  // AHB side
  // ----------------------------------------------------------
  // Ready when nothing is pending, or in the last error cycle
  assign o_hready = ((state == IDLE) && !pend) || (state == ERR2);
  assign o_hresp  = ((state == ERR1) || (state == ERR2)) ? ERROR : OKAY;
  assign o_hrdata = hrdata_q;

  assign accept = i_hsel && i_hready_in && o_hready &&
                  ((i_htrans == HTRANS_NONSEQ) || (i_htrans == HTRANS_SEQ));

  // ----------------------------------------------------------
  // Transfer FSM
  // ----------------------------------------------------------
  always_ff @(posedge i_hclk) begin
    if (i_rst) begin
      state <= IDLE;
      pend  <= 1'b0;
    end else begin
      pend <= accept;  // Only possible while ready, so no overlap
      case (state)
        IDLE: begin
          if (pend) begin
            state <= i_dec_valid ? SETUP : ERR1;  // Bad address, no psel
          end
        end
        SETUP:  state <= ACCESS;
        ACCESS: begin
          if (i_pready) begin
            state <= IDLE;  // Slave done, release AHB
          end
        end
        ERR1:    state <= ERR2;
        ERR2:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Address phase, data phase and read return registers
  always_ff @(posedge i_hclk) begin
    if (accept) begin
      paddr_q.word <= i_haddr;
      pwrite_q     <= i_hwrite;
    end
    if (pend) begin
      pwdata_q <= i_hwdata;  // hwdata valid one cycle after address
    end
    if ((state == ACCESS) && i_pready && !pwrite_q) begin
      hrdata_q <= i_prdata;
    end
  end

  // ----------------------------------------------------------
  // APB side
  // ----------------------------------------------------------
  assign o_paddr   = paddr_q;
  assign o_pwrite  = pwrite_q;
  assign o_pwdata  = pwdata_q;
  assign o_pactive = (state == SETUP) || (state == ACCESS);
  assign o_penable = (state == ACCESS);

  // ACCESS always preceded by a SETUP cycle
  a_penable_after_setup : assert property (
    @(posedge i_hclk) disable iff (i_rst)
    $rose(o_penable) |-> $past(o_pactive)
  ) else $error("penable rose without a preceding setup phase");

endmodule

// File: bridge/apb_slot_decode.sv
// APB slot decoder
// Checks the page, selects one of the external slots or the power slot,
// builds byte-lane strobes for the UART-style slots and returns the
// selected read data and ready

`include "apb_sub_cfg.svh"

module apb_slot_decode (
  input  apb_bus_pkg::apb_addr_u                  i_paddr,
  input  logic                                    i_pactive,
  output logic                                    o_valid,
  output logic [`NUM_EXT_SLOTS:0]                 o_psel,
  output apb_bus_pkg::strb_t                      o_pstrb,
  input  logic [`NUM_EXT_SLOTS-1:0][`DATA_W-1:0] i_prdata_ext,
  input  logic [`NUM_EXT_SLOTS-1:0]               i_pready_ext,
  input  logic [`DATA_W-1:0]                      i_prdata_pwr,
  output logic [`DATA_W-1:0]                      o_prdata,
  output logic                                    o_pready
);

  import apb_bus_pkg::*;

  // Slot numbers count from the slot field of the window base
  localparam slot_t BASE_SLOT = slot_t'((`APB_BASE >> 16) & 32'hF);

  slot_t slot;
  logic  page_hit;
  logic  is_ext;
  logic  is_pwr;

  assign slot     = i_paddr.f.slot - BASE_SLOT;
  assign page_hit = (i_paddr.f.page == `APB_PAGE);
  assign is_ext   = page_hit && (slot < slot_t'(`NUM_EXT_SLOTS));
  assign is_pwr   = page_hit && (slot == slot_t'(`PWR_SLOT));
  assign o_valid  = is_ext || is_pwr;  // Anything else gets ERROR

  // ----------------------------------------------------------
  // Peripheral selects
  // ----------------------------------------------------------
  always_comb begin
    o_psel = '0;
    for (int i = 0; i < `NUM_EXT_SLOTS; i++) begin
      o_psel[i] = i_pactive && is_ext && (slot == slot_t'(i));
    end
    o_psel[`PWR_SLOT] = i_pactive && is_pwr;
  end

  // Byte slots take one little-endian lane from addr[1:0]
  always_comb begin
    if (is_ext && (slot < slot_t'(`NUM_BYTE_SLOTS))) begin
      o_pstrb = strb_t'(1) << i_paddr.f.offset[1:0];
    end else begin
      o_pstrb = '1;  // Word access
    end
  end

  // ----------------------------------------------------------
  // Read data and ready return
  // ----------------------------------------------------------
  always_comb begin
    o_prdata = '0;    // Unmapped reads return zero
    o_pready = 1'b1;  // and never stall
    for (int i = 0; i < `NUM_EXT_SLOTS; i++) begin
      if (is_ext && (slot == slot_t'(i))) begin
        o_prdata = i_prdata_ext[i];
        o_pready = i_pready_ext[i];
      end
    end
    if (is_pwr) begin
      o_prdata = i_prdata_pwr;  // Power slot is zero-wait
    end
  end

endmodule

// File: common/apb_bus_pkg.sv
// APB bus types
// Address word with its decoder view, slot number, byte strobe
// and the AHB response codes returned by the bridge

`include "apb_sub_cfg.svh"

package apb_bus_pkg;

  // Slot number, address bits [19:16]
  typedef logic [3:0] slot_t;

  // Byte-lane strobe, one bit per byte of the data word
  typedef logic [3:0] strb_t;

  // Decoder view of the APB address
  typedef struct packed {
    logic [11:0] page;    // Must match the APB window
    slot_t       slot;    // 64 KB slot
    logic [15:0] offset;  // Register offset inside the slot
  } apb_addr_s;

  // Same 32-bit address, either as a raw bus word or split into fields
  typedef union packed {
    logic [`DATA_W-1:0] word;  // As driven on paddr
    apb_addr_s          f;     // As decoded
  } apb_addr_u;

  // AHB-lite response, only OKAY and ERROR are produced
  typedef enum logic [1:0] {
    OKAY  = 2'd0,
    ERROR = 2'd1
  } hresp_e;

endpackage

// File: common/apb_sub_cfg.svh
// APB subsystem configuration
// Address map, slot layout, data width and power-domain counts
// shared by the bridge, the decoder and the power block

`ifndef APB_SUB_CFG_SVH
`define APB_SUB_CFG_SVH

// ----------------------------------------------------------
// Address map
// ----------------------------------------------------------
`define APB_BASE       32'h0080_0000  // Slot 0 starts here, 64 KB per slot
`define APB_PAGE       12'h008        // Upper 12 address bits of the APB window

// ----------------------------------------------------------
// Slot layout
// ----------------------------------------------------------
`define NUM_EXT_SLOTS  4              // External peripheral slots
`define PWR_SLOT       4              // Internal power-control slot
`define NUM_BYTE_SLOTS 2              // Slots below this are byte-wide (UART style)

// Bus width
`define DATA_W         32

// ----------------------------------------------------------
// Power control
// ----------------------------------------------------------
`define NUM_DOMAINS    6              // SMC, UART, MAC0..MAC3
`define NUM_IRQ        8              // Interrupt sources seen by wake logic

`endif

// File: common/pwr_ctrl_if.sv
// Power-control link
// Carries the gate and isolate state from the power registers to
// the wake/gate logic, and the wake strobe back

interface pwr_ctrl_if;

  pwr_pkg::domain_t dom_gate;     // 1 = domain clock gated off
  logic             isolate_mem;  // Hibernation, memories isolated
  logic             wake_pulse;   // Single-cycle wake strobe, no back-pressure

  // Register block side
  modport regs (
    output dom_gate,
    output isolate_mem,
    input  wake_pulse
  );

  // Wake and clock-gate side
  modport gate (
    input  dom_gate,
    input  isolate_mem,
    output wake_pulse
  );

endinterface

// File: common/pwr_pkg.sv
// Power-control types
// Domain vector, register map of the power slot and the
// interrupt index that may wake the system from hibernation

`include "apb_sub_cfg.svh"

package pwr_pkg;

  // One bit per gated domain
  // Bit 0 SMC, bit 1 UART, bits 2..5 MAC0..MAC3
  typedef logic [`NUM_DOMAINS-1:0] domain_t;

  // Register offsets inside the power slot
  localparam logic [15:0] PWR_GATE_OFS = 16'h0000;  // Clock-gate bits
  localparam logic [15:0] PWR_ISO_OFS  = 16'h0004;  // Memory isolate (hibernation)
  localparam logic [15:0] PWR_WAKE_OFS = 16'h0008;  // Sticky wake status, write 1 to clear

  // GPIO interrupt, the only wake source while isolated
  localparam int GPIO_IRQ_IDX = 2;

endpackage

// File: power/pwr_ctrl_regs.sv
// Power-control register block
// APB slave with domain clock-gate bits, the memory isolate bit and
// a sticky wake status that raises the wake interrupt

`include "apb_sub_cfg.svh"

module pwr_ctrl_regs (
  input  logic               i_hclk,
  input  logic               i_rst,
  // APB slave
  input  logic               i_psel,
  input  logic               i_penable,
  input  logic               i_pwrite,
  input  logic [15:0]        i_paddr,    // Offset within the power slot
  input  logic [`DATA_W-1:0] i_pwdata,
  output logic [`DATA_W-1:0] o_prdata,
  output logic               o_wake_irq,
  // To wake/gate logic
  pwr_ctrl_if.regs           ctrl
);

  import pwr_pkg::*;

  domain_t gate_q;
  logic    iso_q;
  logic    wake_q;
  logic    wr_en;

  // Write lands on the ACCESS edge, slot never inserts waits
  assign wr_en = i_psel && i_penable && i_pwrite;

  // ----------------------------------------------------------
  // Registers
  // ----------------------------------------------------------
  always_ff @(posedge i_hclk) begin
    if (i_rst) begin
      gate_q <= '0;  // All domains clocked
      iso_q  <= 1'b0;
      wake_q <= 1'b0;
    end else begin
      if (wr_en && (i_paddr == PWR_GATE_OFS)) begin
        gate_q <= i_pwdata[`NUM_DOMAINS-1:0];
      end
      if (wr_en && (i_paddr == PWR_ISO_OFS)) begin
        iso_q <= i_pwdata[0];
      end
      if (wr_en && (i_paddr == PWR_WAKE_OFS) && i_pwdata[0]) begin
        wake_q <= 1'b0;  // W1C
      end
      // Wake beats a same-cycle software write
      if (ctrl.wake_pulse) begin
        wake_q <= 1'b1;
        gate_q <= '0;    // Ungate every domain
      end
    end
  end

  // Read mux, zero-extended fields
  always_comb begin
    o_prdata = '0;
    if (i_psel) begin
      case (i_paddr)
        PWR_GATE_OFS: o_prdata[`NUM_DOMAINS-1:0] = gate_q;
        PWR_ISO_OFS:  o_prdata[0] = iso_q;
        PWR_WAKE_OFS: o_prdata[0] = wake_q;
        default:      o_prdata = '0;
      endcase
    end
  end

  assign o_wake_irq       = wake_q;
  assign ctrl.dom_gate    = gate_q;
  assign ctrl.isolate_mem = iso_q;

endmodule

// File: power/pwr_wake_gate.sv
// Wake detection and domain clock enables
// Any interrupt wakes from sleep, only GPIO wakes from hibernation.
// Clock enables are registered from the gate bits, forced on for scan

`include "apb_sub_cfg.svh"

module pwr_wake_gate (
  input  logic                 i_hclk,
  input  logic                 i_rst,
  input  logic [`NUM_IRQ-1:0]  i_irq,
  input  logic                 i_scan_mode,
  output pwr_pkg::domain_t     o_clk_en,
  pwr_ctrl_if.gate             ctrl
);

  import pwr_pkg::*;

  logic    wake_cond;
  logic    wake_cond_q;
  logic    wake_pulse_q;
  domain_t clk_en_q;

  // ----------------------------------------------------------
  // Wake event
  // ----------------------------------------------------------
  // Hibernation listens to GPIO only
  assign wake_cond = ctrl.isolate_mem ? i_irq[GPIO_IRQ_IDX] : (|i_irq);

  always_ff @(posedge i_hclk) begin
    if (i_rst) begin
      wake_cond_q  <= 1'b0;
      wake_pulse_q <= 1'b0;
    end else begin
      wake_cond_q  <= wake_cond;
      wake_pulse_q <= wake_cond && !wake_cond_q;  // Rising edge only
    end
  end

  assign ctrl.wake_pulse = wake_pulse_q;

  // ----------------------------------------------------------
  // Clock enables
  // ----------------------------------------------------------
  always_ff @(posedge i_hclk) begin
    if (i_rst) begin
      clk_en_q <= '1;
    end else begin
      clk_en_q <= ~ctrl.dom_gate;  // Gate bit set = clock off
    end
  end

  assign o_clk_en = i_scan_mode ? '1 : clk_en_q;  // Scan keeps everything clocked

  // One strobe per wake event, a held interrupt must not repeat it
  a_wake_single : assert property (
    @(posedge i_hclk) disable iff (i_rst)
    ctrl.wake_pulse |=> !ctrl.wake_pulse
  ) else $error("wake_pulse held for more than one cycle");

endmodule

// File: source/apb_subsystem.sv
// APB peripheral subsystem front end
// AHB-lite slave port, AHB to APB bridge, slot decoder and the
// internal power-control slot with wake and clock-enable logic

`include "apb_sub_cfg.svh"

module apb_subsystem (
  input  logic                                 i_hclk,
  input  logic                                 i_rst,
  // AHB-lite slave
  input  logic                                 i_hsel,
  input  logic [31:0]                          i_haddr,
  input  logic [1:0]                           i_htrans,
  input  logic                                 i_hwrite,
  input  logic [`DATA_W-1:0]                   i_hwdata,
  input  logic                                 i_hready_in,
  output logic [`DATA_W-1:0]                   o_hrdata,
  output logic                                 o_hready,
  output logic [1:0]                           o_hresp,
  // APB to external slots
  output logic [`NUM_EXT_SLOTS-1:0]            o_psel,
  output logic                                 o_penable,
  output logic [31:0]                          o_paddr,
  output logic                                 o_pwrite,
  output logic [`DATA_W-1:0]                   o_pwdata,
  output logic [3:0]                           o_pstrb,
  input  logic [`NUM_EXT_SLOTS*`DATA_W-1:0]    i_prdata,  // Slot 0 in low word
  input  logic [`NUM_EXT_SLOTS-1:0]            i_pready,
  // Power control
  input  logic [`NUM_IRQ-1:0]                  i_irq,
  input  logic                                 i_scan_mode,
  output logic [`NUM_DOMAINS-1:0]              o_clk_en,
  output logic                                 o_wake_irq
);

  import apb_bus_pkg::*;

  apb_addr_u                paddr;
  hresp_e                   hresp;
  logic                     dec_valid;
  logic                     pactive;
  logic                     penable;
  logic                     pwrite;
  logic [`DATA_W-1:0]       pwdata;
  logic [`NUM_EXT_SLOTS:0]  psel_all;   // Top bit is the power slot
  logic [`DATA_W-1:0]       prdata_mux;
  logic                     pready_mux;
  logic [`DATA_W-1:0]       prdata_pwr;

  pwr_ctrl_if u_pwr_if ();

  // ----------------------------------------------------------
  // Bridge and decoder
  // ----------------------------------------------------------
  ahb_apb_bridge u_bridge (
    .i_hclk      (i_hclk),
    .i_rst       (i_rst),
    .i_hsel      (i_hsel),
    .i_haddr     (i_haddr),
    .i_htrans    (i_htrans),
    .i_hwrite    (i_hwrite),
    .i_hwdata    (i_hwdata),
    .i_hready_in (i_hready_in),
    .o_hrdata    (o_hrdata),
    .o_hready    (o_hready),
    .o_hresp     (hresp),
    .i_dec_valid (dec_valid),
    .i_prdata    (prdata_mux),
    .i_pready    (pready_mux),
    .o_paddr     (paddr),
    .o_pwrite    (pwrite),
    .o_pwdata    (pwdata),
    .o_pactive   (pactive),
    .o_penable   (penable)
  );

  apb_slot_decode u_decode (
    .i_paddr      (paddr),
    .i_pactive    (pactive),
    .o_valid      (dec_valid),
    .o_psel       (psel_all),
    .o_pstrb      (o_pstrb),
    .i_prdata_ext (i_prdata),
    .i_pready_ext (i_pready),
    .i_prdata_pwr (prdata_pwr),
    .o_prdata     (prdata_mux),
    .o_pready     (pready_mux)
  );

  // ----------------------------------------------------------
  // Power-control slot
  // ----------------------------------------------------------
  pwr_ctrl_regs u_pwr_regs (
    .i_hclk     (i_hclk),
    .i_rst      (i_rst),
    .i_psel     (psel_all[`PWR_SLOT]),
    .i_penable  (penable),
    .i_pwrite   (pwrite),
    .i_paddr    (paddr.f.offset),
    .i_pwdata   (pwdata),
    .o_prdata   (prdata_pwr),
    .o_wake_irq (o_wake_irq),
    .ctrl       (u_pwr_if)
  );

  pwr_wake_gate u_wake_gate (
    .i_hclk      (i_hclk),
    .i_rst       (i_rst),
    .i_irq       (i_irq),
    .i_scan_mode (i_scan_mode),
    .o_clk_en    (o_clk_en),
    .ctrl        (u_pwr_if)
  );

  // Pin-level APB
  assign o_psel    = psel_all[`NUM_EXT_SLOTS-1:0];
  assign o_penable = penable;
  assign o_paddr   = paddr.word;
  assign o_pwrite  = pwrite;
  assign o_pwdata  = pwdata;
  assign o_hresp   = hresp;

endmodule

// File: tests/tb_apb_subsystem.sv
// Testbench for the APB subsystem front end
// Drives AHB transfers from a stimulus table, models four APB register
// slaves with random wait states, and checks responses, strobes,
// clock enables and the wake logic

`include "apb_sub_cfg.svh"

module tb_apb_subsystem;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_ROWS   = 26;

  typedef enum int {K_WR, K_RD, K_IRQ, K_CLK} kind_e;

  // One stimulus row
  typedef struct {
    string       name;
    kind_e       kind;
    logic [31:0] addr;
    logic [31:0] wdata;  // Write data, irq vector or scan mode
    logic [31:0] exp;    // Read data, pstrb, wake_irq or clk_en
    bit          err;    // Expect an AHB ERROR response
  } row_t;

  logic                              clk;
  logic                              rst;
  logic                              hsel;
  logic [31:0]                       haddr;
  logic [1:0]                        htrans;
  logic                              hwrite;
  logic [`DATA_W-1:0]                hwdata;
  logic                              hready_in;
  logic [`DATA_W-1:0]                hrdata;
  logic                              hready;
  logic [1:0]                        hresp;
  logic [`NUM_EXT_SLOTS-1:0]         psel;
  logic                              penable;
  logic [31:0]                       paddr;
  logic                              pwrite;
  logic [`DATA_W-1:0]                pwdata;
  logic [3:0]                        pstrb;
  logic [`NUM_EXT_SLOTS*`DATA_W-1:0] prdata;
  logic [`NUM_EXT_SLOTS-1:0]         pready;
  logic [`NUM_IRQ-1:0]               irq;
  logic                              scan_mode;
  logic [`NUM_DOMAINS-1:0]           clk_en;
  logic                              wake_irq;

  // APB slave models with four words per slot
  logic [31:0] mem [`NUM_EXT_SLOTS][4];
  logic [1:0]  wait_cnt [`NUM_EXT_SLOTS];
  logic [1:0]  widx;
  integer      seed = 32'he1f7_fb23;
  int          rnd;

  row_t rows [NUM_ROWS];
  int   n_rows;
  int   n_pass;
  int   n_fail;

  apb_subsystem dut (
    .i_hclk (clk), .i_rst (rst),
    .i_hsel (hsel), .i_haddr (haddr), .i_htrans (htrans), .i_hwrite (hwrite),
    .i_hwdata (hwdata), .i_hready_in (hready_in),
    .o_hrdata (hrdata), .o_hready (hready), .o_hresp (hresp),
    .o_psel (psel), .o_penable (penable), .o_paddr (paddr), .o_pwrite (pwrite),
    .o_pwdata (pwdata), .o_pstrb (pstrb), .i_prdata (prdata), .i_pready (pready),
    .i_irq (irq), .i_scan_mode (scan_mode), .o_clk_en (clk_en), .o_wake_irq (wake_irq)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------------------------------------
  // APB slave models
  // ------------------------------------------------------------
  function automatic logic [31:0] fill_word(input int s, input int w);
    return {8'h5A, 8'(s), 8'(w * 4), 8'hC3};  // Slot and word in the pattern
  endfunction

  assign widx = paddr[3:2];

  always_comb begin
    for (int s = 0; s < `NUM_EXT_SLOTS; s++) begin
      prdata[s*32 +: 32] = mem[s][widx];
      pready[s]          = (wait_cnt[s] == 2'd0);
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `NUM_EXT_SLOTS; s++) begin
        for (int w = 0; w < 4; w++) begin
          mem[s][w] <= fill_word(s, w);
        end
        wait_cnt[s] <= 2'd0;
      end
    end else begin
      for (int s = 0; s < `NUM_EXT_SLOTS; s++) begin
        if (psel[s] && !penable) begin
          rnd = $random(seed);
          wait_cnt[s] <= rnd[1:0];  // 0 to 3 wait states in ACCESS
        end else if (psel[s] && penable) begin
          if (wait_cnt[s] != 2'd0) begin
            wait_cnt[s] <= wait_cnt[s] - 2'd1;
          end else if (pwrite) begin
            for (int b = 0; b < 4; b++) begin
              if (pstrb[b]) mem[s][widx][b*8 +: 8] <= pwdata[b*8 +: 8];  // Strobed lanes only
            end
          end
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------
  function automatic void add_row(input string name, input kind_e kind, input logic [31:0] addr,
                                  input logic [31:0] wdata, input logic [31:0] exp,
                                  input bit err);
    rows[n_rows].name  = name;
    rows[n_rows].kind  = kind;
    rows[n_rows].addr  = addr;
    rows[n_rows].wdata = wdata;
    rows[n_rows].exp   = exp;
    rows[n_rows].err   = err;
    n_rows++;
  endfunction

  task automatic load_table();
    add_row("wr_slot2_w0",    K_WR,  32'h0082_0000, 32'hDEAD_BEEF, 32'hF, 0);
    add_row("rd_slot2_w0",    K_RD,  32'h0082_0000, 32'h0, 32'hDEAD_BEEF, 0);
    add_row("wr_slot3_w1",    K_WR,  32'h0083_0004, 32'h1234_5678, 32'hF, 0);
    add_row("rd_slot3_w1",    K_RD,  32'h0083_0004, 32'h0, 32'h1234_5678, 0);
    add_row("wr_slot2_w3",    K_WR,  32'h0082_000C, 32'hCAFE_F00D, 32'hF, 0);
    add_row("rd_slot2_w3",    K_RD,  32'h0082_000C, 32'h0, 32'hCAFE_F00D, 0);
    add_row("rd_slot3_w2",    K_RD,  32'h0083_0008, 32'h0, 32'h5A03_08C3, 0);  // Untouched
    add_row("wr_slot0_byte1", K_WR,  32'h0080_0001, 32'h1122_3344, 32'h2, 0);
    add_row("rd_slot0_w0",    K_RD,  32'h0080_0000, 32'h0, 32'h5A00_33C3, 0);
    add_row("wr_bad_page",    K_WR,  32'h0090_0000, 32'h5555_AAAA, 32'h0, 1);
    add_row("rd_slot6",       K_RD,  32'h0086_0000, 32'h0, 32'h0, 1);
    add_row("wr_gate",        K_WR,  32'h0084_0000, 32'h15, 32'h0, 0);
    add_row("clk_en_gated",   K_CLK, 32'h0, 32'h0, 32'h2A, 0);
    add_row("clk_en_scan",    K_CLK, 32'h0, 32'h1, 32'h3F, 0);
    add_row("clk_en_no_scan", K_CLK, 32'h0, 32'h0, 32'h2A, 0);
    add_row("rd_gate",        K_RD,  32'h0084_0000, 32'h0, 32'h15, 0);
    add_row("irq5_awake",     K_IRQ, 32'h0, 32'h20, 32'h1, 0);
    add_row("rd_gate_woken",  K_RD,  32'h0084_0000, 32'h0, 32'h0, 0);
    add_row("rd_wake_set",    K_RD,  32'h0084_0008, 32'h0, 32'h1, 0);
    add_row("wr_wake_clear",  K_WR,  32'h0084_0008, 32'h1, 32'h0, 0);
    add_row("wr_iso_on",      K_WR,  32'h0084_0004, 32'h1, 32'h0, 0);
    add_row("irq5_hibernate", K_IRQ, 32'h0, 32'h20, 32'h0, 0);  // Not GPIO so no wake
    add_row("irq2_hibernate", K_IRQ, 32'h0, 32'h04, 32'h1, 0);
    add_row("wr_wake_clear2", K_WR,  32'h0084_0008, 32'h1, 32'h0, 0);
    add_row("irq_none",       K_IRQ, 32'h0, 32'h0, 32'h0, 0);
    add_row("rd_wake_clear",  K_RD,  32'h0084_0008, 32'h0, 32'h0, 0);
  endtask

  // ------------------------------------------------------------
  // Drivers
  // ------------------------------------------------------------
  // One AHB transfer sampled at falling edges until hready
  task automatic ahb_xfer(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic [1:0] resp,
                          output logic psel_seen, output logic [3:0] strb,
                          output int err_cycles);
    bit done;
    done       = 1'b0;
    psel_seen  = 1'b0;
    strb       = 4'h0;
    err_cycles = 0;
    @(posedge clk);
    hsel   <= 1'b1;
    haddr  <= addr;
    htrans <= 2'b10;  // NONSEQ
    hwrite <= wr;
    @(posedge clk);   // Address phase accepted here
    hsel   <= 1'b0;
    htrans <= 2'b00;
    hwdata <= wdata;  // Data phase
    while (!done) begin
      @(negedge clk);
      if (psel != '0) begin
        psel_seen = 1'b1;
        strb      = pstrb;
      end
      if (hresp == 2'd1) err_cycles++;
      if (hready) done = 1'b1;
    end
    rdata = hrdata;
    resp  = hresp;
  endtask

  // Single-cycle interrupt pulse with the status seen two edges later
  task automatic pulse_irq(input logic [`NUM_IRQ-1:0] vec);
    @(posedge clk);
    irq <= vec;
    @(posedge clk);
    irq <= '0;
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic set_scan(input logic mode);
    @(posedge clk);
    scan_mode <= mode;
    @(negedge clk);
  endtask

  task automatic run_row(input int idx);
    row_t        r;
    logic [31:0] rdata;
    logic [1:0]  resp;
    logic        psel_seen;
    logic [3:0]  strb;
    int          err_cycles;
    bit          ok;
    r  = rows[idx];
    ok = 1'b1;
    case (r.kind)
      K_WR, K_RD: begin
        ahb_xfer(r.addr, r.kind == K_WR, r.wdata, rdata, resp, psel_seen, strb, err_cycles);
        if (resp != (r.err ? 2'd1 : 2'd0)) begin
          $display("ERROR %s: expected hresp %0d, actual %0d", r.name, r.err, resp);
          ok = 1'b0;
        end
        if (r.err && psel_seen) begin
          $display("FAIL %s: a peripheral select rose for an invalid address", r.name);
          ok = 1'b0;
        end
        if (r.err && (err_cycles != 2)) begin
          $display("ERROR %s: expected 2 error cycles, actual %0d", r.name, err_cycles);
          ok = 1'b0;
        end
        if (!r.err && (r.kind == K_RD) && (rdata !== r.exp)) begin
          $display("ERROR %s: expected %h, actual %h", r.name, r.exp, rdata);
          ok = 1'b0;
        end
        if (!r.err && (r.kind == K_WR) && (strb !== r.exp[3:0])) begin
          $display("ERROR %s: expected pstrb %b, actual %b", r.name, r.exp[3:0], strb);
          ok = 1'b0;
        end
      end
      K_IRQ: begin
        pulse_irq(r.wdata[`NUM_IRQ-1:0]);
        if (wake_irq !== r.exp[0]) begin
          $display("ERROR %s: expected wake_irq %b, actual %b", r.name, r.exp[0], wake_irq);
          ok = 1'b0;
        end
      end
      default: begin
        set_scan(r.wdata[0]);
        if (clk_en !== r.exp[`NUM_DOMAINS-1:0]) begin
          $display("ERROR %s: expected clk_en %h, actual %h", r.name,
                   r.exp[`NUM_DOMAINS-1:0], clk_en);
          ok = 1'b0;
        end
      end
    endcase
    if (ok) begin
      n_pass++;
      $display("PASS  %s", r.name);
    end else begin
      n_fail++;
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence and watchdog
  // ------------------------------------------------------------
  initial begin
    rst       = 1'b1;
    hsel      = 1'b0;
    haddr     = '0;
    htrans    = 2'b00;
    hwrite    = 1'b0;
    hwdata    = '0;
    hready_in = 1'b1;
    irq       = '0;
    scan_mode = 1'b0;
    n_rows    = 0;
    n_pass    = 0;
    n_fail    = 0;
    load_table();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    @(posedge clk);
    $display("Summary: %0d tests passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    #(NUM_ROWS * 10 * CLK_PERIOD);
    $display("Timeout: the stimulus table did not finish in time");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
